// File: build.f
+incdir+src
src/uart_sys_pkg.sv
src/uart_rx.sv
src/byte_fifo.sv
src/cmd_engine.sv
src/uart_tx.sv
src/uart_sys_top.sv
dv/uart_sys_tb.sv

// File: dv/uart_sys_tb.sv
// Self-checking testbench for the UART console; drives the serial line and switches and checks every response.
`timescale 1ns/1ps
`include "uart_sys_config.svh"

module uart_sys_tb;

	localparam int CLKS_PER_BIT = `UART_CLKS_PER_BIT;
	localparam int NUM_CMDS = 93;
	localparam int TIMEOUT_CYCLES = NUM_CMDS * 30 * CLKS_PER_BIT + 100;

	// Command opcodes and response bytes as the reference model sees them.
	localparam logic [3:0] M_OP_SET_LED = 4'h1;
	localparam logic [3:0] M_OP_GET_SW = 4'h2;
	localparam logic [7:0] M_RSP_ACK = 8'h4B;
	localparam logic [7:0] M_RSP_SW_BASE = 8'h50;
	localparam logic [7:0] M_RSP_UNKNOWN = 8'h3F;
	localparam logic [7:0] M_RSP_FRAME_ERR = 8'h21;

	logic        clk;
	logic        i_arst_n;
	logic        i_rxd;
	logic [3:0]  i_sw;
	wire         o_txd;
	wire  [3:0]  o_led;

	logic [31:0] rng_state;
	logic [3:0]  model_led;
	int          err_count;
	int          errs_at_start;
	int          tests_ok;
	int          tests_bad;
	int          cycle_count = 0;

	uart_sys_top dut0 (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_rxd    (i_rxd),
		.i_sw     (i_sw),
		.o_txd    (o_txd),
		.o_led    (o_led)
	);

	initial begin
		clk = 1'b0;
		forever #20 clk = ~clk;
	end

	always @(posedge clk) begin
		cycle_count <= cycle_count + 1;
		if (cycle_count >= TIMEOUT_CYCLES) begin
			$display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
			$display("Some tests failed");
			$finish;
		end
	end

	// ==============================
	// Helpers
	// ==============================

	function automatic logic [15:0] next_rand();
		rng_state = rng_state * 32'd1103515245 + 32'd12345;
		return rng_state[30:15];
	endfunction

	// The reference model returns the response byte and tracks the LED register.
	function automatic logic [7:0] model_step(input logic [7:0] cmd, input logic bad_stop,
		input logic [3:0] sw);
		if (bad_stop) begin
			return M_RSP_FRAME_ERR;
		end
		if (cmd[7:4] == M_OP_SET_LED) begin
			model_led = cmd[3:0];
			return M_RSP_ACK;
		end
		if (cmd[7:4] == M_OP_GET_SW) begin
			return M_RSP_SW_BASE + {4'h0, sw};
		end
		return M_RSP_UNKNOWN;
	endfunction

	task automatic check_eq(input string name, input logic [7:0] expected,
		input logic [7:0] actual);
		if (expected !== actual) begin
			$display("FAILED %s: expected 0x%02h, actual 0x%02h", name, expected, actual);
			err_count++;
		end
	endtask

	// Leaves the caller 2 ns after a rising edge, where inputs change.
	task automatic wait_cycles(input int n);
		repeat (n) @(posedge clk);
		#2;
	endtask

	task automatic send_char(input logic [7:0] data, input logic bad_stop);
		logic [9:0] frame;
		frame = {~bad_stop, data, 1'b0};
		for (int i = 0; i < 10; i++) begin
			i_rxd = frame[i];
			wait_cycles(CLKS_PER_BIT);
		end
		i_rxd = 1'b1;
	endtask

	// Samples on falling clock edges, half a bit after the start edge and then once per bit.
	task automatic recv_char(output logic [7:0] data, output logic [3:0] led_at_start,
		output logic stop_bit);
		@(negedge o_txd);
		led_at_start = o_led;
		repeat (CLKS_PER_BIT / 2) @(negedge clk);
		for (int i = 0; i < 8; i++) begin
			repeat (CLKS_PER_BIT) @(negedge clk);
			data[i] = o_txd;
		end
		repeat (CLKS_PER_BIT) @(negedge clk);
		stop_bit = o_txd;
	endtask

	task automatic do_command(input string name, input logic [7:0] cmd, input logic bad_stop);
		logic [7:0] expected;
		logic [7:0] rsp;
		logic [3:0] led_seen;
		logic       stop_bit;
		expected = model_step(cmd, bad_stop, i_sw);
		fork
			send_char(cmd, bad_stop);
			recv_char(rsp, led_seen, stop_bit);
		join
		wait_cycles(1);
		check_eq(name, expected, rsp);
		check_eq({name, " stop bit"}, 8'h01, {7'h0, stop_bit});
		check_eq({name, " led"}, {4'h0, model_led}, {4'h0, led_seen});
	endtask

	task automatic finish_test(input string name);
		if (err_count == errs_at_start) begin
			$display("Test %s: ok", name);
			tests_ok++;
		end else begin
			$display("Test %s: %0d mismatches", name, err_count - errs_at_start);
			tests_bad++;
		end
		errs_at_start = err_count;
	endtask

	task automatic idle_check();
		for (int i = 0; i < 50; i++) begin
			@(negedge clk);
			check_eq("idle txd", 8'h01, {7'h0, o_txd});
			check_eq("idle led", 8'h00, {4'h0, o_led});
		end
		wait_cycles(1);
	endtask

	// Three commands go out without a gap while the responses are collected alongside.
	task automatic back_to_back();
		logic [7:0]  cmds [3];
		logic [7:0]  expected [3];
		logic [7:0]  rsps [3];
		logic [3:0]  leds_seen [3];
		logic        stop_bits [3];
		logic [15:0] r;
		r = next_rand();
		cmds[0] = {M_OP_SET_LED, r[3:0]};
		cmds[1] = {M_OP_GET_SW, r[7:4]};
		cmds[2] = {4'h7, r[11:8]};
		for (int k = 0; k < 3; k++) begin
			expected[k] = model_step(cmds[k], 1'b0, i_sw);
		end
		fork
			for (int k = 0; k < 3; k++) begin
				send_char(cmds[k], 1'b0);
			end
			for (int k = 0; k < 3; k++) begin
				recv_char(rsps[k], leds_seen[k], stop_bits[k]);
			end
		join
		wait_cycles(1);
		for (int k = 0; k < 3; k++) begin
			check_eq($sformatf("burst #%0d", k), expected[k], rsps[k]);
			check_eq($sformatf("burst #%0d stop bit", k), 8'h01, {7'h0, stop_bits[k]});
			check_eq($sformatf("burst #%0d led", k), {4'h0, model_led}, {4'h0, leds_seen[k]});
		end
		check_eq("burst led", {4'h0, model_led}, {4'h0, o_led});
	endtask

	// ==============================
	// Test sequence
	// ==============================

	initial begin
		logic [15:0] r;
		logic [7:0]  b;
		i_arst_n = 1'b0;
		i_rxd = 1'b1;
		i_sw = 4'h0;
		rng_state = 32'd90146;
		model_led = 4'h0;
		err_count = 0;
		errs_at_start = 0;
		tests_ok = 0;
		tests_bad = 0;
		wait_cycles(3);
		i_arst_n = 1'b1;

		idle_check();
		finish_test("idle after reset");

		for (int i = 0; i < 40; i++) begin
			r = next_rand();
			do_command($sformatf("set_led #%0d", i), {M_OP_SET_LED, r[3:0]}, 1'b0);
		end
		finish_test("set LED");

		for (int i = 0; i < 20; i++) begin
			do begin
				r = next_rand();
			end while (r[3:0] == i_sw);
			i_sw = r[3:0];
			// The switch synchronizer needs the value held for two cycles.
			wait_cycles(4);
			do_command($sformatf("get_sw #%0d", i), {M_OP_GET_SW, r[7:4]}, 1'b0);
		end
		finish_test("get switches");

		for (int i = 0; i < 20; i++) begin
			do begin
				r = next_rand();
				b = r[7:0];
			end while (b[7:4] == M_OP_SET_LED || b[7:4] == M_OP_GET_SW);
			do_command($sformatf("unknown #%0d", i), b, 1'b0);
		end
		finish_test("unknown opcode");

		for (int i = 0; i < 10; i++) begin
			r = next_rand();
			b = r[7:0];
			// Every other character looks like an LED update with a different nibble.
			if (i % 2 == 0) begin
				b = {M_OP_SET_LED, model_led ^ (r[3:0] | 4'h1)};
			end
			do_command($sformatf("bad_stop #%0d", i), b, 1'b1);
		end
		finish_test("framing error");

		back_to_back();
		finish_test("back to back");

		$display("Tests ok: %0d, tests failing: %0d", tests_ok, tests_bad);
		if (tests_bad == 0 && err_count == 0) begin
			$display("All tests passed");
		end else begin
			$display("Some tests failed");
		end
		$finish;
	end

endmodule

// File: run.sh
#!/usr/bin/env bash
# Builds the UART console testbench with Verilator, runs it and checks the log.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log
OBJ=obj_dir

verilator --binary --timing --assert -j 0 \
	--top-module uart_sys_tb \
	-f build.f \
	-Mdir "$OBJ" \
	-o uart_sys_sim

"./$OBJ/uart_sys_sim" | tee "$LOG"

if grep -q "Some tests failed" "$LOG"; then
	echo "Simulation reported failures"
	exit 1
fi

if ! grep -q "All tests passed" "$LOG"; then
	echo "Simulation ended without a result"
	exit 1
fi

echo "Simulation clean"

// File: src/byte_fifo.sv
// Small synchronous FIFO with a type-parameter payload; used for received frames and response bytes.
`timescale 1ns/1ps
`include "uart_sys_config.svh"

module byte_fifo #(
	parameter type T = logic [7:0]
) (
	input  logic clk,
	input  logic i_arst_n,
	input  logic i_push,
	input  T     i_data,
	input  logic i_pop,
	output T     o_data,
	output logic o_empty,
	output logic o_full
);

	localparam int DEPTH = `UART_FIFO_DEPTH;
	localparam int AW = $clog2(DEPTH);

	// Pointers carry one extra bit to tell full from empty.
	logic [AW:0] wr_ptr;
	logic [AW:0] rd_ptr;
	T            mem [DEPTH];
	logic        push_ok;
	logic        pop_ok;

	assign o_empty = (wr_ptr == rd_ptr);
	assign o_full  = (wr_ptr[AW] != rd_ptr[AW]) && (wr_ptr[AW-1:0] == rd_ptr[AW-1:0]);

	// A push into a full FIFO is dropped and a pop from an empty one is ignored.
	assign push_ok = i_push && !o_full;
	assign pop_ok  = i_pop && !o_empty;

	// The head entry is shown without a register stage.
	assign o_data = mem[rd_ptr[AW-1:0]];

	// ==============================
	// Pointers
	// ==============================

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
		end else begin
			if (push_ok) begin
				wr_ptr <= wr_ptr + 1'b1;
			end
			if (pop_ok) begin
				rd_ptr <= rd_ptr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		if (push_ok) begin
			mem[wr_ptr[AW-1:0]] <= i_data;
		end
	end

	// Both neighbours are expected to look at the level flags before they strobe.
	a_no_overflow : assert property (
		@(posedge clk) disable iff (!i_arst_n) !(i_push && o_full)
	) else $error("byte_fifo: push while full, entry dropped");

	a_no_underflow : assert property (
		@(posedge clk) disable iff (!i_arst_n) !(i_pop && o_empty)
	) else $error("byte_fifo: pop while empty");

endmodule

// File: src/cmd_engine.sv
// Command decoder for the console; pops one frame, pushes one response and owns the LED register.
`timescale 1ns/1ps

module cmd_engine
	import uart_sys_pkg::*;
(
	input  logic       clk,
	input  logic       i_arst_n,
	input  logic       i_rx_empty,
	input  rx_frame_t  i_rx_frame,
	output logic       o_rx_pop,
	input  logic       i_tx_full,
	output logic       o_tx_push,
	output logic [7:0] o_tx_byte,
	input  logic [3:0] i_sw,
	output logic [3:0] o_led
);

	logic [3:0] sw_meta;
	logic [3:0] sw_sync;
	logic       accept;
	logic [3:0] opcode;
	logic [3:0] operand;
	logic       is_set_led;

	// ==============================
	// Switch synchronizer
	// ==============================

	// The switches are asynchronous to clk, so a read sees them after two flops.
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			sw_meta <= '0;
			sw_sync <= '0;
		end else begin
			sw_meta <= i_sw;
			sw_sync <= sw_meta;
		end
	end

	// ==============================
	// Decode
	// ==============================

	// A frame is handled only when its response has somewhere to go.
	// Otherwise it waits in the receive FIFO.
	assign accept    = !i_rx_empty && !i_tx_full;
	assign o_rx_pop  = accept;
	assign o_tx_push = accept;

	assign opcode  = i_rx_frame.data[7:4];
	assign operand = i_rx_frame.data[3:0];

	// A damaged character never touches the LEDs, whatever its opcode looks like.
	assign is_set_led = !i_rx_frame.frame_err && (opcode == OP_SET_LED);

	always_comb begin
		if (i_rx_frame.frame_err) begin
			o_tx_byte = RSP_FRAME_ERR;
		end else if (opcode == OP_SET_LED) begin
			o_tx_byte = RSP_ACK;
		end else if (opcode == OP_GET_SW) begin
			o_tx_byte = RSP_SW_BASE | {4'h0, sw_sync};
		end else begin
			o_tx_byte = RSP_UNKNOWN;
		end
	end

	// ==============================
	// LED register
	// ==============================

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			o_led <= '0;
		end else if (accept && is_set_led) begin
			o_led <= operand;
		end
	end

	// Every frame taken out produces exactly one response byte.
	a_pop_push_pair : assert property (
		@(posedge clk) disable iff (!i_arst_n) o_rx_pop == o_tx_push
	) else $error("cmd_engine: pop and push out of step");

endmodule

// File: src/uart_rx.sv
// Serial 8N1 receiver; instantiate on the console input to get one frame strobe per character.
`timescale 1ns/1ps
`include "uart_sys_config.svh"

module uart_rx
	import uart_sys_pkg::*;
(
	input  logic      clk,
	input  logic      i_arst_n,
	input  logic      i_rxd,
	output logic      o_frame_valid,
	output rx_frame_t o_frame
);

	localparam int CLKS_PER_BIT = `UART_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);
	localparam logic [CNT_W-1:0] HALF_BIT = CNT_W'(CLKS_PER_BIT / 2 - 1);

	typedef enum logic [1:0] {
		RX_IDLE,
		RX_START,
		RX_DATA,
		RX_STOP
	} state_t;

	state_t           state;
	logic [CNT_W-1:0] cnt;
	logic [2:0]       bit_idx;
	logic             rxd_meta;
	logic             rxd_s;
	logic             rxd_prev;
	logic [7:0]       shreg;
	logic             bit_done;

	// The line idles high, so the synchronizer resets to ones.
	// The extra stage gives a clean falling edge for start detection.
	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			rxd_meta <= 1'b1;
			rxd_s    <= 1'b1;
			rxd_prev <= 1'b1;
		end else begin
			rxd_meta <= i_rxd;
			rxd_s    <= rxd_meta;
			rxd_prev <= rxd_s;
		end
	end

	assign bit_done = (cnt == FULL_BIT);

	// ==============================
	// Frame state machine
	// ==============================

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			state         <= RX_IDLE;
			cnt           <= '0;
			bit_idx       <= '0;
			o_frame_valid <= 1'b0;
		end else begin
			o_frame_valid <= 1'b0;
			case (state)
			RX_IDLE: begin
				// Only a falling edge starts a character, so a stuck-low line after a bad stop
				// bit is not taken as a new start bit.
				if (rxd_prev && !rxd_s) begin
					state <= RX_START;
					cnt   <= '0;
				end
			end
			RX_START: begin
				if (cnt == HALF_BIT) begin
					// A glitch that is high again by mid-bit is ignored.
					state   <= rxd_s ? RX_IDLE : RX_DATA;
					cnt     <= '0;
					bit_idx <= '0;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
			RX_DATA: begin
				if (bit_done) begin
					cnt     <= '0;
					bit_idx <= bit_idx + 1'b1;
					if (bit_idx == 3'd7) begin
						state <= RX_STOP;
					end
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
			RX_STOP: begin
				if (bit_done) begin
					state         <= RX_IDLE;
					cnt           <= '0;
					o_frame_valid <= 1'b1;
				end else begin
					cnt <= cnt + 1'b1;
				end
			end
			default: state <= RX_IDLE;
			endcase
		end
	end

	// Data bits arrive LSB first and are sampled at the middle of each bit.
	always_ff @(posedge clk) begin
		if (state == RX_DATA && bit_done) begin
			shreg <= {rxd_s, shreg[7:1]};
		end
		if (state == RX_STOP && bit_done) begin
			o_frame.data      <= shreg;
			o_frame.frame_err <= !rxd_s;
		end
	end

	// A character takes ten bit periods, so two frames can never be adjacent.
	a_single_strobe : assert property (
		@(posedge clk) disable iff (!i_arst_n) o_frame_valid |=> !o_frame_valid
	) else $error("uart_rx: frame strobe held for two cycles");

endmodule

// File: src/uart_sys_config.svh
// Build-time settings for the UART console; include this wherever the bit timing or FIFO depth is needed.
`ifndef UART_SYS_CONFIG_SVH
`define UART_SYS_CONFIG_SVH

// ==============================
// Serial timing
// ==============================

// Clock cycles in one serial bit period.
// The receiver samples at the middle of each bit, so keep this even and at least four.
`define UART_CLKS_PER_BIT 8

// ==============================
// Buffering
// ==============================

// Entries in each of the receive and transmit FIFOs.
// This must be a power of two because the FIFO pointers wrap on their low bits.
`define UART_FIFO_DEPTH 4

`endif

// File: src/uart_sys_pkg.sv
// Shared types and command encodings for the UART console; import it into any block that decodes frames.
package uart_sys_pkg;

	// ==============================
	// Receive frame
	// ==============================

	// One received character together with its framing status.
	// The error flag is set when the stop bit was sampled low.
	typedef struct packed {
		logic       frame_err;
		logic [7:0] data;
	} rx_frame_t;

	// ==============================
	// Command opcodes
	// ==============================

	// The opcode sits in the upper nibble of a command byte.
	// Load the low nibble of the command into the LED register.
	localparam logic [3:0] OP_SET_LED = 4'h1;

	// Report the synchronized switch value.
	localparam logic [3:0] OP_GET_SW = 4'h2;

	// ==============================
	// Response bytes
	// ==============================

	// Sent after an LED update ('K').
	localparam logic [7:0] RSP_ACK = 8'h4B;

	// The switch value is added into the low nibble of this byte ('P' for all zeros).
	localparam logic [7:0] RSP_SW_BASE = 8'h50;

	// Sent for any opcode the engine does not know ('?').
	localparam logic [7:0] RSP_UNKNOWN = 8'h3F;

	// Sent when a character arrived with a bad stop bit ('!').
	localparam logic [7:0] RSP_FRAME_ERR = 8'h21;

endpackage

// File: src/uart_sys_top.sv
// Top level of the UART console; connects receiver, FIFOs, command engine and transmitter.
`timescale 1ns/1ps

module uart_sys_top
	import uart_sys_pkg::*;
(
	input  logic       clk,
	input  logic       i_arst_n,
	input  logic       i_rxd,
	input  logic [3:0] i_sw,
	output logic       o_txd,
	output logic [3:0] o_led
);

	// Receive path.
	logic      rx_valid;
	rx_frame_t rx_frame;
	rx_frame_t rx_head;
	logic      rx_pop;
	logic      rx_empty;

	// Transmit path.
	logic       tx_push;
	logic [7:0] tx_byte;
	logic [7:0] tx_head;
	logic       tx_pop;
	logic       tx_empty;
	logic       tx_full;

	uart_rx uart_rx0 (
		.clk           (clk),
		.i_arst_n      (i_arst_n),
		.i_rxd         (i_rxd),
		.o_frame_valid (rx_valid),
		.o_frame       (rx_frame)
	);

	// The receive FIFO never needs its full flag because the receiver cannot stall.
	byte_fifo #(.T(rx_frame_t)) rx_fifo0 (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_push   (rx_valid),
		.i_data   (rx_frame),
		.i_pop    (rx_pop),
		.o_data   (rx_head),
		.o_empty  (rx_empty),
		.o_full   ()
	);

	cmd_engine cmd_engine0 (
		.clk        (clk),
		.i_arst_n   (i_arst_n),
		.i_rx_empty (rx_empty),
		.i_rx_frame (rx_head),
		.o_rx_pop   (rx_pop),
		.i_tx_full  (tx_full),
		.o_tx_push  (tx_push),
		.o_tx_byte  (tx_byte),
		.i_sw       (i_sw),
		.o_led      (o_led)
	);

	byte_fifo #(.T(logic [7:0])) tx_fifo0 (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_push   (tx_push),
		.i_data   (tx_byte),
		.i_pop    (tx_pop),
		.o_data   (tx_head),
		.o_empty  (tx_empty),
		.o_full   (tx_full)
	);

	uart_tx uart_tx0 (
		.clk      (clk),
		.i_arst_n (i_arst_n),
		.i_empty  (tx_empty),
		.i_byte   (tx_head),
		.o_pop    (tx_pop),
		.o_txd    (o_txd)
	);

endmodule

// File: src/uart_tx.sv
// Serial 8N1 transmitter; drains the response FIFO one byte at a time onto the console output.
`timescale 1ns/1ps
`include "uart_sys_config.svh"

module uart_tx
	import uart_sys_pkg::*;
(
	input  logic       clk,
	input  logic       i_arst_n,
	input  logic       i_empty,
	input  logic [7:0] i_byte,
	output logic       o_pop,
	output logic       o_txd
);

	localparam int CLKS_PER_BIT = `UART_CLKS_PER_BIT;
	localparam int CNT_W = $clog2(CLKS_PER_BIT + 1);
	localparam logic [CNT_W-1:0] FULL_BIT = CNT_W'(CLKS_PER_BIT - 1);

	// Start bit, eight data bits and the stop bit.
	localparam logic [3:0] LAST_BIT = 4'd9;

	logic             busy;
	logic [CNT_W-1:0] cnt;
	logic [3:0]       bit_cnt;
	logic [9:0]       shreg;

	// A new character is taken as soon as the previous one has fully gone out.
	assign o_pop = !busy && !i_empty;

	// The line is driven straight from the low end of the shift register.
	assign o_txd = shreg[0];

	// ==============================
	// Shifter
	// ==============================

	always_ff @(posedge clk or negedge i_arst_n) begin
		if (!i_arst_n) begin
			busy    <= 1'b0;
			cnt     <= '0;
			bit_cnt <= '0;
			shreg   <= '1;
		end else if (o_pop) begin
			// Frame is stop, data LSB first, start, so bit 0 goes out first.
			busy    <= 1'b1;
			cnt     <= '0;
			bit_cnt <= '0;
			shreg   <= {1'b1, i_byte, 1'b0};
		end else if (busy) begin
			if (cnt == FULL_BIT) begin
				cnt   <= '0;
				// Ones fill in behind, which leaves the line idle high at the end.
				shreg <= {1'b1, shreg[9:1]};
				if (bit_cnt == LAST_BIT) begin
					busy <= 1'b0;
				end else begin
					bit_cnt <= bit_cnt + 1'b1;
				end
			end else begin
				cnt <= cnt + 1'b1;
			end
		end
	end

	// Between characters the line sits high.
	a_idle_high : assert property (
		@(posedge clk) disable iff (!i_arst_n) !busy |-> o_txd
	) else $error("uart_tx: line low while idle");

endmodule
